// File: all.f
src/ooo_pkg.sv
src/inst_decoder.sv
src/reorder_buffer.sv
src/register_file.sv
src/reservation_station.sv
src/alu.sv
src/cpu_core.sv
verification/cpu_core_tb.sv

// File: verification/cpu_core_tb.sv
// random OP/OP-IMM stream over x0..x5 with a forced dependency chain; stops at the first mismatch
`timescale 1ns/1ps

module cpu_core_tb import ooo_pkg::*; ();

  localparam int NUM_INSTS     = 400;
  localparam int CHAIN_FIRST   = 150;
  localparam int CHAIN_LAST    = 210;
  localparam int FULL_TIMEOUT  = 200;
  localparam int DRAIN_TIMEOUT = 1000;
  localparam time DRIVE_DELAY  = 1;

  logic    clk_in;
  logic    rst_n;
  logic    rdy_in;
  logic    inst_valid;
  inst_t   inst;
  logic    inst_full;
  logic    commit_valid;
  commit_t commit;

  inst_t           program_mem [NUM_INSTS];
  logic [XLEN-1:0] model_regs  [REG_COUNT];
  commit_t         expected_q  [$];
  int              accepted;
  int              commits_seen;
  logic            saw_full;

  cpu_core cpu_core_i (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .rdy_in       (rdy_in),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_full    (inst_full),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  always #50 clk_in = ~clk_in;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_commit(commit_t got, commit_t exp);
    if (got.rd !== exp.rd) begin
      abort_run($sformatf("Error: commit.rd got %h expected %h", got.rd, exp.rd));
    end else if (got.value !== exp.value) begin
      abort_run($sformatf("Error: commit.value got %h expected %h", got.value, exp.value));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic logic is_alu_opcode(inst_t ins);
    return (ins.r_fmt.opcode == OPC_OP) || (ins.r_fmt.opcode == OPC_OP_IMM);
  endfunction

  // RV32I semantics applied to the model registers
  function automatic commit_t expected_commit(inst_t ins);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    logic            alt;
    commit_t         res;
    a = model_regs[ins.r_fmt.rs1];
    if (ins.r_fmt.opcode == OPC_OP) begin
      b   = model_regs[ins.r_fmt.rs2];
      alt = ins.r_fmt.funct7[5];
    end else begin
      b   = {{(XLEN-12){ins.i_fmt.imm12[11]}}, ins.i_fmt.imm12};
      // addi has no subtract form
      alt = (ins.i_fmt.funct3 == 3'b101) && ins.i_fmt.imm12[10];
    end
    case (ins.r_fmt.funct3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    res.rd    = ins.r_fmt.rd;
    res.value = r;
    return res;
  endfunction

  function automatic inst_t random_inst(int idx);
    inst_t      ins;
    reg_id_t    rd;
    reg_id_t    rs1;
    logic [2:0] f3;
    logic       alt;
    rd  = reg_id_t'($urandom_range(5));
    rs1 = reg_id_t'($urandom_range(5));
    // long chain through x3 to fill the rob
    if (idx >= CHAIN_FIRST && idx < CHAIN_LAST) begin
      rd  = reg_id_t'(3);
      rs1 = reg_id_t'(3);
    end
    f3  = 3'($urandom_range(7));
    alt = 1'($urandom_range(1));
    ins = inst_t'($urandom);
    ins.r_fmt.rd     = rd;
    ins.r_fmt.rs1    = rs1;
    ins.r_fmt.funct3 = f3;
    case ($urandom_range(9))
      0: ins.r_fmt.opcode = 7'b0000011;
      1, 2, 3, 4: begin
        ins.r_fmt.opcode = OPC_OP;
        ins.r_fmt.rs2    = reg_id_t'($urandom_range(5));
        ins.r_fmt.funct7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
      end
      default: begin
        ins.i_fmt.opcode = OPC_OP_IMM;
        if (f3 == 3'b001 || f3 == 3'b101) begin
          ins.i_fmt.imm12[11:5] = (alt && f3 == 3'b101) ? 7'b0100000 : 7'b0;
        end
      end
    endcase
    return ins;
  endfunction

  // counts dispatches at the edge that samples them
  always @(posedge clk_in) begin
    if (rst_n && rdy_in && inst_valid && is_alu_opcode(inst)) begin
      accepted++;
    end
  end

  always @(negedge clk_in) begin : commit_monitor
    commit_t exp;
    if (rst_n) begin
      if (inst_full) begin
        saw_full = 1'b1;
      end
      if (!rdy_in) begin
        check_bit("commit_valid", commit_valid, 1'b0);
      end else begin
        if (commit_valid) begin
          if (commits_seen >= accepted) begin
            abort_run("a commit appeared with no instruction outstanding");
          end else begin
            exp = expected_q.pop_front();
            check_commit(commit, exp);
            commits_seen++;
          end
        end
        check_bit("inst_full", inst_full, (accepted - commits_seen) == ROB_DEPTH);
      end
    end
  end

  task automatic wait_until_not_full();
    int cycles;
    cycles = 0;
    inst_valid = 1'b0;
    while (inst_full) begin
      if (cycles >= FULL_TIMEOUT) begin
        abort_run("inst_full stayed high and no entry was freed");
      end else begin
        cycles++;
        @(posedge clk_in);
        #DRIVE_DELAY;
      end
    end
  endtask

  initial begin
    int pause_len;
    int cycles;
    clk_in       = 1'b0;
    rst_n        = 1'b0;
    rdy_in       = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    accepted     = 0;
    commits_seen = 0;
    saw_full     = 1'b0;
    void'($urandom(32'h66dce018));

    for (int r = 0; r < REG_COUNT; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < NUM_INSTS; i++) begin
      program_mem[i] = random_inst(i);
      if (is_alu_opcode(program_mem[i])) begin
        expected_q.push_back(expected_commit(program_mem[i]));
        if (program_mem[i].r_fmt.rd != '0) begin
          model_regs[program_mem[i].r_fmt.rd] = expected_q[$].value;
        end
      end
    end

    repeat (8) @(posedge clk_in);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    for (int i = 0; i < NUM_INSTS; i++) begin
      if ($urandom_range(15) == 0) begin
        pause_len  = $urandom_range(6, 1);
        inst_valid = 1'b0;
        rdy_in     = 1'b0;
        repeat (pause_len) begin
          @(posedge clk_in);
          #DRIVE_DELAY;
        end
        rdy_in = 1'b1;
      end
      wait_until_not_full();
      inst_valid = 1'b1;
      inst       = program_mem[i];
      @(posedge clk_in);
      #DRIVE_DELAY;
      inst_valid = 1'b0;
    end

    cycles = 0;
    while (expected_q.size() != 0) begin
      if (cycles >= DRAIN_TIMEOUT) begin
        abort_run("the core stopped committing before the program finished");
      end else begin
        cycles++;
        @(posedge clk_in);
      end
    end
    // settle so a stray extra commit is still caught
    repeat (10) @(posedge clk_in);

    if (!saw_full) begin
      abort_run("inst_full never rose, back-pressure was not exercised");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// File: src/cpu_core.sv
// ALU-only core without fetch, branches or memory; inst_valid must respect inst_full and rdy_in
`timescale 1ns/1ps

module cpu_core import ooo_pkg::*; (
  input  logic    clk_in,
  input  logic    rst_n,
  input  logic    rdy_in,
  input  logic    inst_valid,
  input  inst_t   inst,
  output logic    inst_full,
  output logic    commit_valid,
  output commit_t commit
);

  logic            dispatch_valid;
  dispatch_t       dispatch;
  rob_tag_t        alloc_tag;
  reg_status_t     src1_status;
  reg_status_t     src2_status;
  logic            lookup1_ready;
  logic [XLEN-1:0] lookup1_value;
  logic            lookup2_ready;
  logic [XLEN-1:0] lookup2_value;
  logic            issue_valid;
  issue_t          issue;
  logic            cdb_valid;
  cdb_t            cdb;
  rob_tag_t        commit_tag;

  inst_decoder decoder_i (
    .inst_valid     (inst_valid),
    .inst           (inst),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch)
  );

  reorder_buffer rob_i (
    .clk_in         (clk_in),
    .rst_n          (rst_n),
    .rdy_in         (rdy_in),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .lookup1_tag    (src1_status.tag),
    .lookup2_tag    (src2_status.tag),
    .cdb_valid      (cdb_valid),
    .cdb            (cdb),
    .alloc_tag      (alloc_tag),
    .inst_full      (inst_full),
    .lookup1_ready  (lookup1_ready),
    .lookup1_value  (lookup1_value),
    .lookup2_ready  (lookup2_ready),
    .lookup2_value  (lookup2_value),
    .commit_valid   (commit_valid),
    .commit         (commit),
    .commit_tag     (commit_tag)
  );

  register_file rf_i (
    .clk_in         (clk_in),
    .rst_n          (rst_n),
    .rdy_in         (rdy_in),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .alloc_tag      (alloc_tag),
    .commit_valid   (commit_valid),
    .commit         (commit),
    .commit_tag     (commit_tag),
    .src1_status    (src1_status),
    .src2_status    (src2_status)
  );

  reservation_station rs_i (
    .clk_in         (clk_in),
    .rst_n          (rst_n),
    .rdy_in         (rdy_in),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .alloc_tag      (alloc_tag),
    .src1_status    (src1_status),
    .src2_status    (src2_status),
    .lookup1_ready  (lookup1_ready),
    .lookup1_value  (lookup1_value),
    .lookup2_ready  (lookup2_ready),
    .lookup2_value  (lookup2_value),
    .cdb_valid      (cdb_valid),
    .cdb            (cdb),
    .issue_valid    (issue_valid),
    .issue          (issue)
  );

  alu alu_i (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .rdy_in      (rdy_in),
    .issue_valid (issue_valid),
    .issue       (issue),
    .cdb_valid   (cdb_valid),
    .cdb         (cdb)
  );

endmodule

// File: src/alu.sv
// single-cycle ALU with no back-pressure; result appears on the bus one cycle after issue
`timescale 1ns/1ps

module alu import ooo_pkg::*; (
  input  logic   clk_in,
  input  logic   rst_n,
  input  logic   rdy_in,
  input  logic   issue_valid,
  input  issue_t issue,
  output logic   cdb_valid,
  output cdb_t   cdb
);

  logic [$clog2(XLEN)-1:0] shamt;
  logic [XLEN-1:0]         result;
  logic                    cdb_valid_q;

  assign shamt = issue.v2[$clog2(XLEN)-1:0];

  always_comb begin
    case (issue.op)
      ALU_ADD:  result = issue.v1 + issue.v2;
      ALU_SUB:  result = issue.v1 - issue.v2;
      ALU_SLL:  result = issue.v1 << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(issue.v1) < $signed(issue.v2)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, issue.v1 < issue.v2};
      ALU_XOR:  result = issue.v1 ^ issue.v2;
      ALU_SRL:  result = issue.v1 >> shamt;
      ALU_SRA:  result = $unsigned($signed(issue.v1) >>> shamt);
      ALU_OR:   result = issue.v1 | issue.v2;
      ALU_AND:  result = issue.v1 & issue.v2;
      default:  result = '0;
    endcase
  end

  assign cdb_valid = cdb_valid_q & rdy_in;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      cdb_valid_q <= 1'b0;
    end else if (rdy_in) begin
      cdb_valid_q <= issue_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      cdb <= '{tag: issue.tag, value: result};
    end
  end

endmodule

// File: src/reservation_station.sv
// relies on the rob full flag for space; one issue per cycle, stored entries before the new one
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; (
  input  logic            clk_in,
  input  logic            rst_n,
  input  logic            rdy_in,
  input  logic            dispatch_valid,
  input  dispatch_t       dispatch,
  input  rob_tag_t        alloc_tag,
  input  reg_status_t     src1_status,
  input  reg_status_t     src2_status,
  input  logic            lookup1_ready,
  input  logic [XLEN-1:0] lookup1_value,
  input  logic            lookup2_ready,
  input  logic [XLEN-1:0] lookup2_value,
  input  logic            cdb_valid,
  input  cdb_t            cdb,
  output logic            issue_valid,
  output issue_t          issue
);

  logic [RS_DEPTH-1:0] ent_valid;
  rob_tag_t            ent_tag  [RS_DEPTH];
  alu_op_e             ent_op   [RS_DEPTH];
  operand_t            ent_src1 [RS_DEPTH];
  operand_t            ent_src2 [RS_DEPTH];
  operand_t            cur_src1 [RS_DEPTH];
  operand_t            cur_src2 [RS_DEPTH];
  logic [RS_DEPTH-1:0] ent_rdy;
  operand_t            new_src1;
  operand_t            new_src2;
  logic                new_rdy;
  logic                sel_found;
  logic [RS_IDX_W-1:0] sel_idx;
  logic [RS_IDX_W-1:0] free_idx;
  logic                store_new;
  issue_t              issue_next;
  logic                issue_valid_q;

  // a waiting operand takes the value when its tag is on the bus
  function automatic operand_t snoop(operand_t src, logic bus_valid, cdb_t bus);
    operand_t res;
    res = src;
    if (src.waiting && bus_valid && (bus.tag == src.tag)) begin
      res.waiting = 1'b0;
      res.value   = bus.value;
    end
    return res;
  endfunction

  // register file first, then the rob entry, then the bus
  function automatic operand_t resolve(reg_status_t st, logic rob_rdy,
                                       logic [XLEN-1:0] rob_val, logic bus_valid, cdb_t bus);
    operand_t res;
    res = '{waiting: st.busy, tag: st.tag, value: st.value};
    if (st.busy && rob_rdy) begin
      res.waiting = 1'b0;
      res.value   = rob_val;
    end
    return snoop(res, bus_valid, bus);
  endfunction

  always_comb begin
    new_src1 = resolve(src1_status, lookup1_ready, lookup1_value, cdb_valid, cdb);
    new_src2 = resolve(src2_status, lookup2_ready, lookup2_value, cdb_valid, cdb);
    if (dispatch.use_imm) begin
      new_src2 = '{waiting: 1'b0, tag: '0, value: dispatch.imm};
    end
    new_rdy = dispatch_valid && !new_src1.waiting && !new_src2.waiting;

    for (int i = 0; i < RS_DEPTH; i++) begin
      cur_src1[i] = snoop(ent_src1[i], cdb_valid, cdb);
      cur_src2[i] = snoop(ent_src2[i], cdb_valid, cdb);
      ent_rdy[i]  = ent_valid[i] && !cur_src1[i].waiting && !cur_src2[i].waiting;
    end

    // scan downwards so the lowest index is the one kept
    sel_found = 1'b0;
    sel_idx   = '0;
    free_idx  = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (ent_rdy[i]) begin
        sel_found = 1'b1;
        sel_idx   = RS_IDX_W'(i);
      end
      if (!ent_valid[i]) begin
        free_idx = RS_IDX_W'(i);
      end
    end

    // the new instruction bypasses the slots when nothing stored is ready
    store_new = dispatch_valid && !(new_rdy && !sel_found);
    if (sel_found) begin
      issue_next = '{tag: ent_tag[sel_idx], op: ent_op[sel_idx],
                     v1: cur_src1[sel_idx].value, v2: cur_src2[sel_idx].value};
    end else begin
      issue_next = '{tag: alloc_tag, op: dispatch.op, v1: new_src1.value, v2: new_src2.value};
    end
  end

  assign issue_valid = issue_valid_q & rdy_in;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid     <= '0;
      issue_valid_q <= 1'b0;
    end else if (rdy_in) begin
      issue_valid_q <= sel_found || new_rdy;
      if (sel_found) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (store_new) begin
        ent_valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      issue <= issue_next;
      for (int i = 0; i < RS_DEPTH; i++) begin
        ent_src1[i] <= cur_src1[i];
        ent_src2[i] <= cur_src2[i];
      end
      if (store_new) begin
        ent_tag[free_idx]  <= alloc_tag;
        ent_op[free_idx]   <= dispatch.op;
        ent_src1[free_idx] <= new_src1;
        ent_src2[free_idx] <= new_src2;
      end
    end
  end

endmodule

// File: src/register_file.sv
// x0 is never written nor marked busy; a same-cycle dispatch to a committing register keeps its tag
`timescale 1ns/1ps

module register_file import ooo_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_n,
  input  logic        rdy_in,
  input  logic        dispatch_valid,
  input  dispatch_t   dispatch,
  input  rob_tag_t    alloc_tag,
  input  logic        commit_valid,
  input  commit_t     commit,
  input  rob_tag_t    commit_tag,
  output reg_status_t src1_status,
  output reg_status_t src2_status
);

  logic [XLEN-1:0]      regs [REG_COUNT];
  rob_tag_t             tags [REG_COUNT];
  logic [REG_COUNT-1:0] busy;

  assign src1_status = '{busy: busy[dispatch.rs1], tag: tags[dispatch.rs1],
                         value: regs[dispatch.rs1]};
  assign src2_status = '{busy: busy[dispatch.rs2], tag: tags[dispatch.rs2],
                         value: regs[dispatch.rs2]};

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
    end else if (rdy_in) begin
      if (commit_valid && (commit.rd != '0)) begin
        regs[commit.rd] <= commit.value;
        // only the youngest writer releases the register
        if (tags[commit.rd] == commit_tag) begin
          busy[commit.rd] <= 1'b0;
        end
      end
      // later assignment, so dispatch wins over commit
      if (dispatch_valid && (dispatch.rd != '0)) begin
        busy[dispatch.rd] <= 1'b1;
        tags[dispatch.rd] <= alloc_tag;
      end
    end
  end

endmodule

// File: src/reorder_buffer.sv
// source must not dispatch while inst_full is high; outputs that strobe are masked while rdy_in is low
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; (
  input  logic            clk_in,
  input  logic            rst_n,
  input  logic            rdy_in,
  input  logic            dispatch_valid,
  input  dispatch_t       dispatch,
  input  rob_tag_t        lookup1_tag,
  input  rob_tag_t        lookup2_tag,
  input  logic            cdb_valid,
  input  cdb_t            cdb,
  output rob_tag_t        alloc_tag,
  output logic            inst_full,
  output logic            lookup1_ready,
  output logic [XLEN-1:0] lookup1_value,
  output logic            lookup2_ready,
  output logic [XLEN-1:0] lookup2_value,
  output logic            commit_valid,
  output commit_t         commit,
  output rob_tag_t        commit_tag
);

  rob_tag_t             head;
  rob_tag_t             tail;
  logic [ROB_TAG_W:0]   count;
  logic [ROB_DEPTH-1:0] ent_ready;
  reg_id_t              ent_rd    [ROB_DEPTH];
  logic [XLEN-1:0]      ent_value [ROB_DEPTH];
  logic                 commit_valid_q;
  logic                 head_hit;
  logic                 retire;

  assign alloc_tag = tail;
  assign inst_full = (count == ROB_DEPTH);

  // ready flags survive retirement, so a just-retired tag still answers lookups
  assign lookup1_ready = ent_ready[lookup1_tag];
  assign lookup1_value = ent_value[lookup1_tag];
  assign lookup2_ready = ent_ready[lookup2_tag];
  assign lookup2_value = ent_value[lookup2_tag];

  // head may retire in the same cycle its result is on the bus
  assign head_hit = cdb_valid && (cdb.tag == head);
  assign retire   = (count != '0) && (ent_ready[head] || head_hit);

  assign commit_valid = commit_valid_q & rdy_in;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      ent_ready      <= '0;
      commit_valid_q <= 1'b0;
    end else if (rdy_in) begin
      commit_valid_q <= retire;
      if (cdb_valid) begin
        ent_ready[cdb.tag] <= 1'b1;
      end
      if (dispatch_valid) begin
        ent_ready[tail] <= 1'b0;
        tail            <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      count <= count + {{ROB_TAG_W{1'b0}}, dispatch_valid} - {{ROB_TAG_W{1'b0}}, retire};
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (dispatch_valid) begin
        ent_rd[tail] <= dispatch.rd;
      end
      if (cdb_valid) begin
        ent_value[cdb.tag] <= cdb.value;
      end
      if (retire) begin
        commit.rd    <= ent_rd[head];
        commit.value <= ent_ready[head] ? ent_value[head] : cdb.value;
        commit_tag   <= head;
      end
    end
  end

endmodule

// File: src/inst_decoder.sv
// purely combinational; any opcode other than OP and OP-IMM is dropped, funct7 is not checked
`timescale 1ns/1ps

module inst_decoder import ooo_pkg::*; (
  input  logic      inst_valid,
  input  inst_t     inst,
  output logic      dispatch_valid,
  output dispatch_t dispatch
);

  logic is_op;
  logic is_op_imm;
  logic alt;

  always_comb begin
    // opcode sits at the same bits in both views
    is_op     = (inst.r_fmt.opcode == OPC_OP);
    is_op_imm = (inst.i_fmt.opcode == OPC_OP_IMM);

    // immediate forms only carry the alternate bit on right shifts
    alt = 1'b0;
    if (is_op) begin
      alt = inst.r_fmt.funct7[5];
    end else if (inst.i_fmt.funct3 == 3'b101) begin
      alt = inst.i_fmt.imm12[10];
    end

    dispatch_valid   = inst_valid && (is_op || is_op_imm);
    dispatch.op      = alu_op_e'({alt, inst.r_fmt.funct3});
    dispatch.rd      = inst.r_fmt.rd;
    dispatch.rs1     = inst.r_fmt.rs1;
    // x0 as rs2 keeps immediate forms free of false dependencies
    dispatch.rs2     = is_op ? inst.r_fmt.rs2 : '0;
    dispatch.use_imm = !is_op;
    dispatch.imm     = {{(XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
  end

endmodule

// File: src/ooo_pkg.sv
// rob and station depths must be powers of two; only RV32I OP and OP-IMM encodings are defined
package ooo_pkg;

  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;
  localparam int ROB_DEPTH = 8;
  localparam int ROB_TAG_W = $clog2(ROB_DEPTH);
  // one station slot per rob entry, so a non-full rob always finds a free slot
  localparam int RS_DEPTH  = ROB_DEPTH;
  localparam int RS_IDX_W  = $clog2(RS_DEPTH);

  typedef logic [$clog2(REG_COUNT)-1:0] reg_id_t;
  typedef logic [ROB_TAG_W-1:0]         rob_tag_t;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011
  } opcode_e;

  // {funct7 alternate bit, funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_id_t    rs2;
      reg_id_t    rs1;
      logic [2:0] funct3;
      reg_id_t    rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      reg_id_t     rs1;
      logic [2:0]  funct3;
      reg_id_t     rd;
      logic [6:0]  opcode;
    } i_fmt;
  } inst_t;

  typedef struct packed {
    alu_op_e         op;
    reg_id_t         rd;
    reg_id_t         rs1;
    reg_id_t         rs2;
    logic            use_imm;
    logic [XLEN-1:0] imm;
  } dispatch_t;

  typedef struct packed {
    logic            busy;
    rob_tag_t        tag;
    logic [XLEN-1:0] value;
  } reg_status_t;

  typedef struct packed {
    logic            waiting;
    rob_tag_t        tag;
    logic [XLEN-1:0] value;
  } operand_t;

  typedef struct packed {
    rob_tag_t        tag;
    alu_op_e         op;
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] v2;
  } issue_t;

  typedef struct packed {
    rob_tag_t        tag;
    logic [XLEN-1:0] value;
  } cdb_t;

  typedef struct packed {
    reg_id_t         rd;
    logic [XLEN-1:0] value;
  } commit_t;

endpackage
